// ==== filelist.f ====
+incdir+hw
hw/ptw_pkg.sv
hw/ptw_miss_arbiter.sv
hw/ptw_req_queue.sv
hw/ptw_walker.sv
hw/ptw_top.sv
verif/ptw_assert.sv
verif/ptw_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= ptw_tb
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/ptw_tb.sv ====
// self-checking testbench; memory model holds one read at a time, fault responses compare perm only
`timescale 1ns/100ps
`include "ptw_macros.svh"

module ptw_tb;
    import ptw_pkg::*;

    logic clk = 1'b0;
    logic rst, i_req_valid, d_req_valid, mem_req_ready, mem_rsp_valid, resp_ready;
    logic i_req_ready, d_req_ready, mem_req_valid, resp_valid;
    ptw_req_t i_req, d_req;
    ptw_resp_t resp;
    logic [`PTW_PA_W-1:0] mem_req_addr;
    logic [63:0] mem_rsp_data;

    logic [63:0] mem [logic [`PTW_PA_W-1:0]];  // page tables by byte address
    logic [63:0] pool_va[$];
    ptw_satp_t pool_satp[$];
    ptw_resp_t exp_tab [int];                   // keyed by {src, tag}
    int acc_q[$];                               // keys in acceptance order
    logic [43:0] next_ppn = 44'h1000;
    logic [6:0] tag_i = '0;
    logic [6:0] tag_d = '0;
    int err_cnt = 0;
    int pending = 0;
    int rsp_cnt = 0;                            // cycles until the read answers
    int rdy_dly = 0;                            // cycles until the read is accepted
    int prev_src = -1;
    int n_pass = 0;
    int n_fail = 0;
    bit timed_out = 0;
    bit rnd_rdy = 0;
    bit prev_both = 0;
    logic [63:0] rsp_word;

    ptw_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [55:0] pte_addr(input logic [43:0] ppn, input logic [63:0] va,
                                             input int l);
        return (56'(ppn) << 12) + (56'(va[12 + 9 * l +: 9]) << 3);
    endfunction

    function automatic logic [63:0] pte_word(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'h0, ppn, 2'b00, flags};
    endfunction

    // independent model of the walk rules
    function automatic ptw_resp_t ptw_ref(input ptw_req_t r);
        ptw_resp_t o;
        logic [43:0] ppn;
        logic [63:0] pte;
        logic [55:0] a;
        int lv;
        logic mis;
        o = '{src: r.src, tag: r.tag, ppn: '0, perm: '0};
        case (r.satp.mode)
            4'd8: lv = 2;
            4'd9: lv = 3;
            4'd10: lv = 4;
            default: return o;  // unknown mode faults
        endcase
        ppn = r.satp.ppn;
        while (lv >= 0) begin
            a = pte_addr(ppn, r.va, lv);
            pte = mem.exists(a) ? mem[a] : 64'h0;
            if (!pte[0]) return o;
            if (pte[1] || pte[3]) begin
                mis = 1'b0;
                ppn = pte[53:10];
                for (int i = 0; i < lv; i++) begin
                    if (ppn[9 * i +: 9] != '0) mis = 1'b1;
                    ppn[9 * i +: 9] = r.va[12 + 9 * i +: 9];  // superpage fill
                end
                if (!mis) begin
                    o.ppn = ppn;
                    o.perm = pte[7:0];
                end
                return o;
            end
            if (lv == 0) return o;  // pointer at the last level
            ppn = pte[53:10];
            lv--;
        end
        return o;
    endfunction

    task automatic add_case(input logic [3:0] mode, input int leaf_lvl, input logic [43:0] lppn,
                            input logic [7:0] flags);
        logic [43:0] ppn;
        logic [63:0] va;
        logic [55:0] a;
        int levels;
        levels = (mode >= 4'd8 && mode <= 4'd10) ? int'(mode) - 5 : 0;
        ppn = 44'h100 * ((levels > 0) ? levels - 2 : 1);  // one root per mode
        va = {$urandom, $urandom};
        if (levels > 0) va[12 + 9 * (levels - 1) +: 9] = 9'(pool_va.size() + 1);
        pool_va.push_back(va);
        pool_satp.push_back({mode, 16'h0, ppn});
        if (levels > 0) begin
            for (int l = levels - 1; l > leaf_lvl; l--) begin
                a = pte_addr(ppn, va, l);
                if (!mem.exists(a)) begin
                    mem[a] = pte_word(next_ppn, 8'h01);
                    next_ppn = next_ppn + 44'd1;
                end
                ppn = mem[a][53:10];
            end
            mem[pte_addr(ppn, va, leaf_lvl)] = pte_word(lppn, flags);
        end
    endtask

    // read accepted at the coming rising edge
    always @(negedge clk) begin
        if (mem_req_valid && mem_req_ready)
            rsp_word = mem.exists(mem_req_addr) ? mem[mem_req_addr] : 64'h0;
    end

    // memory read port and resp_ready
    always @(posedge clk) begin
        #0.5;
        mem_rsp_valid = 1'b0;
        resp_ready = rnd_rdy ? 1'($urandom % 2) : 1'b1;
        if (!rst && mem_req_ready) begin
            mem_req_ready = 1'b0;
            rsp_cnt = 1 + $urandom % 4;
            rdy_dly = $urandom % 4;
        end else if (rsp_cnt > 0) begin
            rsp_cnt--;
            if (rsp_cnt == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = rsp_word;
            end
        end else if (!rst && mem_req_valid) begin
            if (rdy_dly == 0) mem_req_ready = 1'b1;
            else rdy_dly--;
        end
    end

    // acceptance order, alternation and response checks on transfers due at the next edge
    always @(negedge clk) begin
        int key;
        int exp_key;
        int src;
        if (!rst) begin
            if ((i_req_valid && i_req_ready) || (d_req_valid && d_req_ready)) begin
                src = d_req_ready ? 1 : 0;
                acc_q.push_back(d_req_ready ? {24'h0, 1'b1, d_req.tag}
                                            : {24'h0, 1'b0, i_req.tag});
                if (i_req_valid && d_req_valid && prev_both && src == prev_src) begin
                    $display("** Error at %0t: arbiter granted port %0d twice in a row",
                             $time, src);
                    err_cnt++;
                end
                prev_both = i_req_valid && d_req_valid;
                prev_src = src;
            end
            if (resp_valid && resp_ready) begin
                key = {24'h0, resp.src, resp.tag};
                exp_key = (acc_q.size() != 0) ? acc_q.pop_front() : -1;
                if (key != exp_key) begin
                    $display("** Error at %0t: resp key got %h expected %h", $time, key, exp_key);
                    err_cnt++;
                end
                if (!exp_tab.exists(key)) begin
                    $display("response for source/tag %h was not expected", key);
                    err_cnt++;
                end else begin
                    if (resp.perm != exp_tab[key].perm) begin
                        $display("** Error at %0t: resp.perm got %h expected %h", $time,
                                 resp.perm, exp_tab[key].perm);
                        err_cnt++;
                    end
                    if (exp_tab[key].perm != '0 && resp.ppn != exp_tab[key].ppn) begin
                        $display("** Error at %0t: resp.ppn got %h expected %h", $time,
                                 resp.ppn, exp_tab[key].ppn);
                        err_cnt++;
                    end
                    exp_tab.delete(key);
                end
                pending--;
            end
        end
    end

    task automatic send_stream(input ptw_src_e src, input int idx[$], input bit gaps);
        ptw_req_t r;
        int n;
        int g;
        foreach (idx[k]) begin
            if (timed_out) return;
            r.src = src;
            r.tag = (src == PTW_SRC_I) ? tag_i : tag_d;
            if (src == PTW_SRC_I) tag_i = tag_i + 7'd1;
            else tag_d = tag_d + 7'd1;
            r.va = pool_va[idx[k]];
            r.satp = pool_satp[idx[k]];
            exp_tab[{24'h0, src, r.tag}] = ptw_ref(r);
            pending++;
            if (src == PTW_SRC_I) {i_req_valid, i_req} = {1'b1, r};
            else {d_req_valid, d_req} = {1'b1, r};
            n = 0;
            while (1) begin
                @(negedge clk);
                if ((src == PTW_SRC_I) ? i_req_ready : d_req_ready) break;
                n++;
                if (n > 500) begin
                    $display("timeout: request on port %0d was never accepted", src);
                    timed_out = 1;
                    return;
                end
            end
            @(posedge clk);
            #0.5;
            if (src == PTW_SRC_I) i_req_valid = 1'b0;
            else d_req_valid = 1'b0;
            g = gaps ? $urandom % 3 : 0;
            repeat (g) begin
                @(posedge clk);
                #0.5;
            end
        end
    endtask

    task automatic run_test(input string name, input int iq[$], input int dq[$], input bit rnd);
        int e0;
        int n;
        e0 = err_cnt;
        rnd_rdy = rnd;
        fork
            send_stream(PTW_SRC_I, iq, rnd);
            send_stream(PTW_SRC_D, dq, rnd);
        join
        n = 0;
        while (pending != 0 && !timed_out) begin
            @(posedge clk);
            #0.5;
            n++;
            if (n > 3000) begin
                $display("timeout: %0d responses still missing", pending);
                timed_out = 1;
            end
        end
        if (err_cnt == e0 && !timed_out) n_pass++;
        else n_fail++;
        $display("test %s: %s", name, (err_cnt == e0 && !timed_out) ? "ok" : "FAILED");
    endtask

    initial begin
        int none[$];
        int ri[$];
        int rd[$];
        void'($urandom(32'h07be_2f30));
        {rst, i_req_valid, d_req_valid, mem_req_ready, mem_rsp_valid} = 5'b10000;
        {i_req, d_req, mem_rsp_data, resp_ready} = '0;
        add_case(4'd8, 0, 44'({$urandom, $urandom}), 8'hC7);                 // 0 sv39 4k
        add_case(4'd9, 0, 44'({$urandom, $urandom}), 8'hCB);                 // 1 sv48 4k
        add_case(4'd10, 0, 44'({$urandom, $urandom}), 8'hDF);                // 2 sv57 4k
        add_case(4'd8, 1, 44'({$urandom, $urandom}) & ~44'h1ff, 8'hC3);      // 3 2 MiB
        add_case(4'd9, 2, 44'({$urandom, $urandom}) & ~44'h3ffff, 8'hCF);    // 4 1 GiB
        add_case(4'd8, 1, 44'({$urandom, $urandom}) | 44'h1, 8'hC3);         // 5 2 MiB off
        add_case(4'd9, 2, 44'({$urandom, $urandom}) | 44'h200, 8'hC3);       // 6 1 GiB off
        add_case(4'd3, 0, 44'h0, 8'h00);                                     // 7 bad mode
        add_case(4'd8, 0, 44'({$urandom, $urandom}), 8'hC6);                 // 8 V clear
        add_case(4'd9, 0, 44'({$urandom, $urandom}), 8'h01);                 // 9 pointer at 0
        repeat (4) @(posedge clk);
        #0.5 rst = 1'b0;
        run_test("4k_pages", none, '{0, 1, 2}, 0);
        if (!timed_out) run_test("superpages", '{3, 4, 5, 6}, none, 0);
        if (!timed_out) run_test("faults", '{7, 8}, '{9}, 0);
        if (!timed_out)
            run_test("both_ports", '{0, 3, 4, 8, 1, 2, 9, 5}, '{2, 1, 0, 6, 7, 3, 4, 0}, 0);
        for (int k = 0; k < 12; k++) begin
            ri.push_back($urandom % 10);
            rd.push_back($urandom % 10);
        end
        if (!timed_out) run_test("random_backpressure", ri, rd, 1);
        $display("tests ok %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
        if (err_cnt == 0 && n_fail == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verif/ptw_assert.sv ====
// handshake checks on the walker top; all properties are off while rst is high
`timescale 1ns/100ps

module ptw_assert (
    input logic               clk,
    input logic               rst,
    input logic               i_req_ready,
    input logic               d_req_ready,
    input logic               mem_req_valid,
    input logic               mem_req_ready,
    input logic [55:0]        mem_req_addr,
    input logic               resp_valid,
    input logic               resp_ready,
    input ptw_pkg::ptw_resp_t resp
);
    import ptw_pkg::*;

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("resp changed while stalled");

    mem_addr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("mem_req_addr changed while stalled");

    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(i_req_ready && d_req_ready))
        else $error("both miss ports ready at once");

endmodule

bind ptw_top ptw_assert assert_i (.*);

// ==== hw/ptw_top.sv ====
// page table walker top; memory port allows one outstanding read and its response has no ready
`timescale 1ns/100ps
`include "ptw_macros.svh"

module ptw_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_req_valid,
    output logic                 i_req_ready,
    input  ptw_pkg::ptw_req_t    i_req,
    input  logic                 d_req_valid,
    output logic                 d_req_ready,
    input  ptw_pkg::ptw_req_t    d_req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output logic [`PTW_PA_W-1:0] mem_req_addr,
    input  logic                 mem_rsp_valid,
    input  logic [63:0]          mem_rsp_data,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output ptw_pkg::ptw_resp_t   resp
);
    import ptw_pkg::*;

    logic     arb_valid;  // merged miss stream
    logic     arb_ready;
    ptw_req_t arb_req;
    logic     q_valid;    // queue head to walker
    logic     q_ready;
    ptw_req_t q_req;

    ptw_miss_arbiter arb_i (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (i_req_valid),
        .i_req_ready (i_req_ready),
        .i_req       (i_req),
        .d_req_valid (d_req_valid),
        .d_req_ready (d_req_ready),
        .d_req       (d_req),
        .arb_valid   (arb_valid),
        .arb_ready   (arb_ready),
        .arb_req     (arb_req)
    );

    ptw_req_queue queue_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .in_req    (arb_req),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_req   (q_req)
    );

    ptw_walker walker_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (q_valid),
        .req_ready     (q_ready),
        .req           (q_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp)
    );

endmodule

// ==== hw/ptw_walker.sv ====
// one PTE read in flight; no A/D update and no W-without-R check, so perm zero is the only fault mark
`timescale 1ns/100ps
`include "ptw_macros.svh"

module ptw_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  ptw_pkg::ptw_req_t    req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output logic [`PTW_PA_W-1:0] mem_req_addr,
    input  logic                 mem_rsp_valid,
    input  logic [63:0]          mem_rsp_data,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output ptw_pkg::ptw_resp_t   resp
);
    import ptw_pkg::*;

    localparam int PA_W = `PTW_PA_W;

    typedef enum logic [2:0] {
        S_IDLE,   // waiting for a queued request
        S_ADDR,   // entry read held until accepted
        S_WAIT,   // read accepted, response pending
        S_CHECK,  // entry decoded, next read or response issued
        S_DONE    // response held until accepted
    } state_e;

    state_e                                      state;
    logic [`PTW_MAX_LEVELS-1:0][`PTW_VPN_W-1:0]  vpn_q;  // vpn slices of the request
    logic [`PTW_PPN_W-1:0]                       ppn_q;  // table page of the current level
    ptw_level_t                                  lvl_q;
    ptw_src_e                                    src_q;
    logic [`PTW_TAG_W-1:0]                       tag_q;
    ptw_pte_u                                    pte_q;  // last entry read
    ptw_resp_t                                   resp_q;

    ptw_level_t            root_lvl;
    logic                  mode_ok;
    logic [`PTW_PPN_W-1:0] ppn_sel;
    ptw_level_t            lvl_sel;
    logic                  leaf;
    logic                  stop;
    logic                  misaligned;
    logic                  fault;
    ptw_pte_u              fill;      // leaf entry with superpage segments from the vpn
    ptw_resp_t             resp_chk;

    // satp mode decode
    always_comb begin
        mode_ok  = 1'b1;
        root_lvl = '0;
        case (req.satp.mode)
            4'd8:    root_lvl = 3'd2;  // sv39
            4'd9:    root_lvl = 3'd3;  // sv48
            4'd10:   root_lvl = 3'd4;  // sv57
            default: mode_ok = 1'b0;
        endcase
    end

    // entry checks, valid only in S_CHECK
    always_comb begin
        leaf       = pte_q.flat.flags.r | pte_q.flat.flags.x;
        stop       = leaf | ~pte_q.flat.flags.v | (lvl_q == '0);
        misaligned = 1'b0;
        fill       = pte_q;
        for (int i = 0; i < `PTW_MAX_LEVELS - 1; i++) begin
            if (ptw_level_t'(i) < lvl_q) begin
                misaligned = misaligned | (pte_q.seg.ppn_lo[i] != '0);
                fill.seg.ppn_lo[i] = vpn_q[i];
            end
        end
        // a stop without leaf means V clear or a pointer at level 0
        fault = ~pte_q.flat.flags.v | ~leaf | misaligned;

        resp_chk.src = src_q;
        resp_chk.tag = tag_q;
        resp_chk.ppn = fill.flat.ppn;
        if (fault) begin
            resp_chk.perm = '0;
        end else begin
            resp_chk.perm = pte_q.flat.flags;
        end
    end

    // next table comes straight from the entry while in S_CHECK
    always_comb begin
        if (state == S_CHECK && lvl_q != '0) begin
            ppn_sel = pte_q.flat.ppn;
            lvl_sel = lvl_q - 3'd1;
        end else begin
            ppn_sel = ppn_q;
            lvl_sel = lvl_q;
        end
    end

    assign mem_req_addr  = (PA_W'(ppn_sel) << `PTW_PAGE_SHIFT) + (PA_W'(vpn_q[lvl_sel]) << 3);
    assign req_ready     = (state == S_IDLE);
    assign mem_req_valid = (state == S_ADDR) | ((state == S_CHECK) & ~stop);
    assign resp_valid    = (state == S_DONE) | ((state == S_CHECK) & stop);
    assign resp          = (state == S_CHECK) ? resp_chk : resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) state <= mode_ok ? S_ADDR : S_DONE;  // bad mode skips memory
                end
                S_ADDR: begin
                    if (mem_req_ready) state <= S_WAIT;
                end
                S_WAIT: begin
                    if (mem_rsp_valid) state <= S_CHECK;
                end
                S_CHECK: begin
                    if (stop) begin
                        state <= resp_ready ? S_IDLE : S_DONE;
                    end else begin
                        state <= mem_req_ready ? S_WAIT : S_ADDR;
                    end
                end
                S_DONE: begin
                    if (resp_ready) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            vpn_q  <= req.va[`PTW_PAGE_SHIFT +: `PTW_MAX_LEVELS * `PTW_VPN_W];
            ppn_q  <= req.satp.ppn;
            lvl_q  <= root_lvl;
            src_q  <= req.src;
            tag_q  <= req.tag;
            resp_q <= '{src: req.src, tag: req.tag, ppn: '0, perm: '0};  // mode fault answer
        end
        if (mem_rsp_valid && state == S_WAIT) pte_q <= mem_rsp_data;
        if (state == S_CHECK) begin
            ppn_q  <= ppn_sel;
            lvl_q  <= lvl_sel;
            resp_q <= resp_chk;  // held in S_DONE
        end
    end

endmodule

// ==== hw/ptw_req_queue.sv ====
// circular FIFO with registered output side; a full queue accepts a push only alongside a pop
`timescale 1ns/100ps
`include "ptw_macros.svh"

module ptw_req_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  ptw_pkg::ptw_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output ptw_pkg::ptw_req_t out_req
);
    import ptw_pkg::*;

    localparam int DEPTH = `PTW_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ptw_req_t         mem [DEPTH];  // entry storage
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;        // occupied entries
    logic             push;
    logic             pop;

    // wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    assign in_ready  = (count != (PTR_W + 1)'(DEPTH)) | out_ready;  // full but draining
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_req   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_req;
    end

endmodule

// ==== hw/ptw_miss_arbiter.sv ====
// combinational round-robin over two miss ports; grant is held while the queue stalls a request
`timescale 1ns/100ps

module ptw_miss_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req_valid,
    output logic              i_req_ready,
    input  ptw_pkg::ptw_req_t i_req,
    input  logic              d_req_valid,
    output logic              d_req_ready,
    input  ptw_pkg::ptw_req_t d_req,
    output logic              arb_valid,
    input  logic              arb_ready,
    output ptw_pkg::ptw_req_t arb_req
);
    import ptw_pkg::*;

    ptw_src_e last_win;  // port of the last merged transfer
    ptw_src_e lock_src;  // grant kept across a stall
    ptw_src_e pick;
    logic     locked;
    logic     gnt_i;
    logic     gnt_d;

    always_comb begin
        if (locked) begin
            pick = lock_src;  // keep payload stable until it moves
        end else if (i_req_valid && d_req_valid) begin
            pick = (last_win == PTW_SRC_I) ? PTW_SRC_D : PTW_SRC_I;
        end else begin
            pick = d_req_valid ? PTW_SRC_D : PTW_SRC_I;
        end
        gnt_d = d_req_valid & (pick == PTW_SRC_D);
        gnt_i = i_req_valid & (pick == PTW_SRC_I);
    end

    assign arb_valid   = i_req_valid | d_req_valid;
    assign arb_req     = gnt_d ? d_req : i_req;
    assign i_req_ready = arb_ready & gnt_i;
    assign d_req_ready = arb_ready & gnt_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= PTW_SRC_I;  // data wins the first tie
            locked   <= 1'b0;
        end else if (arb_valid && arb_ready) begin
            last_win <= pick;
            locked   <= 1'b0;
        end else if (arb_valid) begin
            locked   <= 1'b1;
            lock_src <= pick;
        end
    end

endmodule

// ==== hw/ptw_pkg.sv ====
// request, response and PTE layouts; bit positions of satp and PTE follow the RISC-V privileged spec
`include "ptw_macros.svh"

package ptw_pkg;

    // width of the truncated top PPN segment, 8 bits for a 44-bit PPN
    localparam int PPN_TOP_W = `PTW_PPN_W - (`PTW_MAX_LEVELS - 1) * `PTW_VPN_W;

    typedef enum logic {
        PTW_SRC_I = 1'b0,  // instruction miss port
        PTW_SRC_D = 1'b1   // data miss port
    } ptw_src_e;

    typedef logic [2:0] ptw_level_t;  // 0 is the leaf level

    typedef struct packed {
        logic [3:0]            mode;  // 8 sv39, 9 sv48, 10 sv57
        logic [15:0]           asid;
        logic [`PTW_PPN_W-1:0] ppn;   // root table page
    } ptw_satp_t;

    typedef struct packed {
        ptw_src_e              src;
        logic [`PTW_TAG_W-1:0] tag;
        logic [`PTW_VA_W-1:0]  va;
        ptw_satp_t             satp;
    } ptw_req_t;

    typedef struct packed {
        ptw_src_e              src;
        logic [`PTW_TAG_W-1:0] tag;
        logic [`PTW_PPN_W-1:0] ppn;
        logic [7:0]            perm;  // zero on any page fault
    } ptw_resp_t;

    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } ptw_pte_flags_t;

    typedef struct packed {
        logic [9:0]            rsvd;
        logic [`PTW_PPN_W-1:0] ppn;   // whole next-level or leaf page
        logic [1:0]            rsw;
        ptw_pte_flags_t        flags;
    } ptw_pte_flat_t;

    typedef struct packed {
        logic [9:0]                                     rsvd;
        logic [PPN_TOP_W-1:0]                           ppn_top;
        logic [`PTW_MAX_LEVELS-2:0][`PTW_VPN_W-1:0]     ppn_lo;  // segment i pairs with vpn i
        logic [1:0]                                     rsw;
        ptw_pte_flags_t                                 flags;
    } ptw_pte_seg_t;

    typedef union packed {
        ptw_pte_flat_t flat;
        ptw_pte_seg_t  seg;
    } ptw_pte_u;

endpackage

// ==== hw/ptw_macros.svh ====
// walker sizes for Sv39/48/57 with 4 KiB pages and 64-bit entries; queue depth must stay >= 1
`ifndef PTW_MACROS_SVH
`define PTW_MACROS_SVH

// address widths
`define PTW_VA_W        64  // full virtual address as seen by the miss ports
`define PTW_PA_W        56  // physical address on the memory read port

// page geometry
`define PTW_PPN_W       44  // physical page number in satp and in every entry
`define PTW_VPN_W       9   // one level's slice of the virtual page number
`define PTW_PAGE_SHIFT  12  // 4 KiB page offset
`define PTW_MAX_LEVELS  5   // Sv57 walks five levels

// request bookkeeping
`define PTW_TAG_W       7   // tag returned unchanged with the response
`define PTW_QUEUE_DEPTH 2   // walk requests buffered ahead of the walker

`endif
